// ==== rtl/fifo_cfg_pkg.sv ====
`default_nettype none

package fifo_cfg_pkg;

   // read width equals one lane
   localparam int LANE_W = 8;
   localparam int N_LANES = 4;

   // depth in bytes and per lane as log2
   localparam int ADDR_W = 6;
   localparam int LANE_ADDR_W = 4;

   localparam int WIDE_W = LANE_W * N_LANES;
   localparam int FIFO_SIZE = 2 ** ADDR_W;
   // one extra bit so a completely full FIFO can be counted
   localparam int LEVEL_W = ADDR_W + 1;

   typedef logic [WIDE_W-1:0] wide_data_t;
   typedef logic [LANE_W-1:0] narrow_data_t;

   // write pointer counts words, read pointer counts bytes
   typedef logic [LANE_ADDR_W-1:0] wide_addr_t;
   typedef logic [ADDR_W-1:0] narrow_addr_t;

   typedef logic [LEVEL_W-1:0] level_t;

endpackage

`default_nettype wire

// ==== rtl/fifo_mem_pkg.sv ====
`default_nettype none

package fifo_mem_pkg;

   // one write command for all lane banks
   typedef struct packed {
      logic [fifo_cfg_pkg::N_LANES-1:0] en;
      fifo_cfg_pkg::wide_addr_t addr;
      fifo_cfg_pkg::narrow_data_t [fifo_cfg_pkg::N_LANES-1:0] data;
   } lane_wr_t;

   // all lanes read the same row
   typedef struct packed {
      logic en;
      fifo_cfg_pkg::wide_addr_t addr;
   } lane_rd_req_t;

   // registered bytes from the banks with lane 0 lowest
   typedef struct packed {
      fifo_cfg_pkg::narrow_data_t [fifo_cfg_pkg::N_LANES-1:0] lane;
   } lane_rd_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/lane_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_ram (
   input  logic                        clk_i,

   input  logic                        w_en_i,
   input  fifo_cfg_pkg::wide_addr_t    w_addr_i,
   input  fifo_cfg_pkg::narrow_data_t  w_data_i,

   input  logic                        r_en_i,
   input  fifo_cfg_pkg::wide_addr_t    r_addr_i,
   output fifo_cfg_pkg::narrow_data_t  r_data_o
);

   import fifo_cfg_pkg::*;

   localparam int DEPTH = 2 ** LANE_ADDR_W;

   narrow_data_t mem_q [DEPTH];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem_q[w_addr_i] <= w_data_i;
      end
   end

   // output register keeps the last byte read
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem_q[r_addr_i];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/ram_2p_asym.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_2p_asym (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic                        clk_en_i,

   // wide write port, word address
   input  logic                        w_en_i,
   input  fifo_cfg_pkg::wide_addr_t    w_addr_i,
   input  fifo_cfg_pkg::wide_data_t    w_data_i,

   // narrow read port, byte address
   input  logic                        r_en_i,
   input  fifo_cfg_pkg::narrow_addr_t  r_addr_i,
   output fifo_cfg_pkg::narrow_data_t  r_data_o,

   output fifo_mem_pkg::lane_wr_t      mem_wr_o,
   output fifo_mem_pkg::lane_rd_req_t  mem_rd_o,
   input  fifo_mem_pkg::lane_rd_rsp_t  mem_rd_i
);

   import fifo_cfg_pkg::*;

   // low byte address bits pick the lane
   localparam int SEL_W = ADDR_W - LANE_ADDR_W;

   typedef logic [SEL_W-1:0] lane_sel_t;

   lane_sel_t rd_sel_q;

   // a word always fills one row across every lane
   assign mem_wr_o.en   = {N_LANES{w_en_i}};
   assign mem_wr_o.addr = w_addr_i;
   assign mem_wr_o.data = w_data_i;

   assign mem_rd_o.en   = r_en_i;
   assign mem_rd_o.addr = r_addr_i[ADDR_W-1:SEL_W];

   // select is registered alongside the bank read
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_sel_q <= '0;
      end else if (clk_en_i && r_en_i) begin
         rd_sel_q <= r_addr_i[SEL_W-1:0];
      end
   end

   assign r_data_o = mem_rd_i.lane[rd_sel_q];

   // a row is never read in the cycle it is written
   a_no_row_collision: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !(w_en_i && r_en_i && (w_addr_i == r_addr_i[ADDR_W-1:SEL_W]))
   );

endmodule

`default_nettype wire

// ==== rtl/fifo_sync_asym.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_sync_asym (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic                        rst_i,
   input  logic                        clk_en_i,

   // write side
   input  logic                        w_en_i,
   input  fifo_cfg_pkg::wide_data_t    w_data_i,
   output logic                        w_full_o,

   // read side
   input  logic                        r_en_i,
   output fifo_cfg_pkg::narrow_data_t  r_data_o,
   output logic                        r_empty_o,

   output fifo_cfg_pkg::level_t        level_o,

   // external lane memory
   output fifo_mem_pkg::lane_wr_t      mem_wr_o,
   output fifo_mem_pkg::lane_rd_req_t  mem_rd_o,
   input  fifo_mem_pkg::lane_rd_rsp_t  mem_rd_i
);

   import fifo_cfg_pkg::*;

   // level steps in bytes
   localparam level_t W_INCR = level_t'(N_LANES);
   localparam level_t R_INCR = level_t'(1);
   localparam level_t MAX_LEVEL = level_t'(FIFO_SIZE);
   // above this a whole word no longer fits
   localparam level_t FULL_LEVEL = MAX_LEVEL - W_INCR;

   logic         w_en_int;
   logic         r_en_int;
   wide_addr_t   w_addr_q;
   narrow_addr_t r_addr_q;
   level_t       level_q;
   level_t       level_nxt;
   logic         r_empty_q;
   logic         w_full_q;

   // requests on a full or empty FIFO are dropped here
   assign w_en_int = w_en_i && !w_full_q && clk_en_i;
   assign r_en_int = r_en_i && !r_empty_q && clk_en_i;

   always_comb begin
      level_nxt = level_q;
      if (w_en_int) begin
         level_nxt = level_nxt + W_INCR;
      end
      if (r_en_int) begin
         level_nxt = level_nxt - R_INCR;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         w_addr_q  <= '0;
         r_addr_q  <= '0;
         level_q   <= '0;
         r_empty_q <= 1'b1;
         w_full_q  <= 1'b0;
      end else if (clk_en_i) begin
         if (rst_i) begin
            w_addr_q  <= '0;
            r_addr_q  <= '0;
            level_q   <= '0;
            r_empty_q <= 1'b1;
            w_full_q  <= 1'b0;
         end else begin
            // pointers wrap on their own width
            if (w_en_int) begin
               w_addr_q <= w_addr_q + 1'b1;
            end
            if (r_en_int) begin
               r_addr_q <= r_addr_q + 1'b1;
            end
            level_q   <= level_nxt;
            r_empty_q <= level_nxt < R_INCR;
            w_full_q  <= level_nxt > FULL_LEVEL;
         end
      end
   end

   assign level_o   = level_q;
   assign r_empty_o = r_empty_q;
   assign w_full_o  = w_full_q;

   ram_2p_asym i_ram_2p_asym (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .clk_en_i (clk_en_i),
      .w_en_i   (w_en_int),
      .w_addr_i (w_addr_q),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_int),
      .r_addr_i (r_addr_q),
      .r_data_o (r_data_o),
      .mem_wr_o (mem_wr_o),
      .mem_rd_o (mem_rd_o),
      .mem_rd_i (mem_rd_i)
   );

   a_level_max: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      level_o <= MAX_LEVEL
   );

   // an effective write needs room for a whole word
   a_no_write_when_full: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      w_en_int |-> (level_q <= FULL_LEVEL)
   );

endmodule

`default_nettype wire

// ==== rtl/fifo_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_subsys_top (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic                        rst_i,
   input  logic                        clk_en_i,

   input  logic                        w_en_i,
   input  fifo_cfg_pkg::wide_data_t    w_data_i,
   output logic                        w_full_o,

   input  logic                        r_en_i,
   output fifo_cfg_pkg::narrow_data_t  r_data_o,
   output logic                        r_empty_o,

   output fifo_cfg_pkg::level_t        level_o
);

   import fifo_cfg_pkg::*;
   import fifo_mem_pkg::*;

   lane_wr_t          mem_wr;
   lane_rd_req_t      mem_rd;
   // each bank drives its own byte of the response
   wire lane_rd_rsp_t mem_rsp;

   fifo_sync_asym i_fifo_sync_asym (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .rst_i     (rst_i),
      .clk_en_i  (clk_en_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_full_o  (w_full_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .level_o   (level_o),
      .mem_wr_o  (mem_wr),
      .mem_rd_o  (mem_rd),
      .mem_rd_i  (mem_rsp)
   );

   for (genvar g = 0; g < N_LANES; g++) begin : g_lane
      lane_ram i_lane_ram (
         .clk_i    (clk_i),
         .w_en_i   (mem_wr.en[g]),
         .w_addr_i (mem_wr.addr),
         .w_data_i (mem_wr.data[g]),
         .r_en_i   (mem_rd.en),
         .r_addr_i (mem_rd.addr),
         .r_data_o (mem_rsp.lane[g])
      );
   end

endmodule

`default_nettype wire

// ==== tests/tb_fifo_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_sync;

   import fifo_cfg_pkg::*;

   localparam int CLK_PERIOD = 4;
   localparam int RESET_CYCLES = 2;
   localparam int FILL_CYCLES = 20;
   localparam int DRAIN_CYCLES = 72;
   localparam int RANDOM_CYCLES = 2000;
   localparam int CLK_EN_CYCLES = 240;
   localparam int CLEAR_CYCLES = 40;
   localparam int TEST_CYCLES = RESET_CYCLES + FILL_CYCLES + DRAIN_CYCLES + RANDOM_CYCLES
                                + CLK_EN_CYCLES + CLEAR_CYCLES;
   localparam int MARGIN_NS = 400;

   typedef struct packed {
      level_t level;
      logic   empty;
      logic   full;
   } status_t;

   logic         clk_i;
   logic         rst_n_i;
   logic         rst_i;
   logic         clk_en_i;
   logic         w_en_i;
   wide_data_t   w_data_i;
   logic         w_full_o;
   logic         r_en_i;
   narrow_data_t r_data_o;
   logic         r_empty_o;
   level_t       level_o;

   // reference model state
   narrow_data_t ref_q[$];
   narrow_data_t exp_data;
   logic         data_valid;
   string        test_name;
   string        chk_name;
   logic [31:0]  lfsr_q;
   int           err_count;
   int           check_count;

   fifo_subsys_top i_dut (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .rst_i     (rst_i),
      .clk_en_i  (clk_en_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_full_o  (w_full_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .level_o   (level_o)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // galois form with taps of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   function automatic status_t expected_status(input int size);
      status_t st;
      st.level = level_t'(size);
      st.empty = (size < 1);
      // a whole word must still fit
      st.full = (size > FIFO_SIZE - N_LANES);
      return st;
   endfunction

   task automatic check_data(input string name, input narrow_data_t exp_v,
                             input narrow_data_t act_v);
      check_count++;
      if (act_v !== exp_v) begin
         err_count++;
         $display("FAIL %s r_data_o: expected 0x%02h actual 0x%02h", name, exp_v, act_v);
      end
   endtask

   task automatic check_level(input string name, input level_t exp_level, input logic exp_empty,
                              input logic exp_full, input level_t act_level,
                              input logic act_empty, input logic act_full);
      check_count++;
      if (act_level !== exp_level) begin
         err_count++;
         $display("FAIL %s level_o: expected %0d actual %0d", name, exp_level, act_level);
      end
      if (act_empty !== exp_empty) begin
         err_count++;
         $display("FAIL %s r_empty_o: expected %0b actual %0b", name, exp_empty, act_empty);
      end
      if (act_full !== exp_full) begin
         err_count++;
         $display("FAIL %s w_full_o: expected %0b actual %0b", name, exp_full, act_full);
      end
   endtask

   // model applies the acceptance rules to its own flags
   always @(posedge clk_i or negedge rst_n_i) begin : model
      status_t st;
      if (!rst_n_i) begin
         ref_q.delete();
         data_valid = 1'b0;
      end else begin
         chk_name = test_name;
         if (clk_en_i) begin
            if (rst_i) begin
               ref_q.delete();
            end else begin
               st = expected_status(ref_q.size());
               if (r_en_i && !st.empty) begin
                  exp_data = ref_q.pop_front();
                  data_valid = 1'b1;
               end
               if (w_en_i && !st.full) begin
                  for (int b = 0; b < N_LANES; b++) begin
                     ref_q.push_back(w_data_i[b*LANE_W +: LANE_W]);
                  end
               end
            end
         end
      end
   end

   // outputs are stable half a period after the active edge
   always @(negedge clk_i) begin : compare
      status_t st;
      st = expected_status(ref_q.size());
      check_level(chk_name, st.level, st.empty, st.full, level_o, r_empty_o, w_full_o);
      if (data_valid) begin
         check_data(chk_name, exp_data, r_data_o);
      end
   end

   task automatic drive(input logic w, input wide_data_t d, input logic r, input logic ce,
                        input logic clr);
      @(negedge clk_i);
      w_en_i   = w;
      w_data_i = d;
      r_en_i   = r;
      clk_en_i = ce;
      rst_i    = clr;
   endtask

   // write probability 1/2^w_bits, read probability 1 - 1/2^r_bits
   task automatic random_traffic(input string name, input int cycles, input int w_bits,
                                 input int r_bits, input logic rand_ce);
      logic [31:0] wb;
      logic [31:0] rb;
      logic [31:0] cb;
      logic [31:0] d;
      test_name = name;
      for (int i = 0; i < cycles; i++) begin
         take_bits(w_bits, wb);
         take_bits(r_bits, rb);
         take_bits(WIDE_W, d);
         cb = 32'h1;
         if (rand_ce) begin
            take_bits(1, cb);
         end
         drive(wb == ((32'h1 << w_bits) - 32'h1), d, rb != 32'h0, cb[0], 1'b0);
      end
   endtask

   initial begin : stimulus
      logic [31:0] d;
      clk_i = 1'b0;
      rst_n_i = 1'b0;
      rst_i = 1'b0;
      clk_en_i = 1'b0;
      w_en_i = 1'b0;
      w_data_i = '0;
      r_en_i = 1'b0;
      lfsr_q = 32'hfe82_4d06;
      err_count = 0;
      check_count = 0;
      data_valid = 1'b0;
      test_name = "reset";
      chk_name = "reset";
      repeat (RESET_CYCLES) @(negedge clk_i);
      rst_n_i = 1'b1;

      // more writes than fit so the last ones get dropped
      test_name = "fill";
      for (int i = 0; i < FILL_CYCLES; i++) begin
         take_bits(WIDE_W, d);
         drive(1'b1, d, 1'b0, 1'b1, 1'b0);
      end

      // runs past empty on purpose
      test_name = "drain";
      for (int i = 0; i < DRAIN_CYCLES; i++) begin
         drive(1'b0, '0, 1'b1, 1'b1, 1'b0);
      end

      random_traffic("random fill", RANDOM_CYCLES / 2, 1, 1, 1'b0);
      random_traffic("random drain", RANDOM_CYCLES / 2, 3, 2, 1'b0);
      random_traffic("clk_en random", 200, 1, 1, 1'b1);

      test_name = "clk_en hold";
      for (int i = 0; i < 2; i++) begin
         take_bits(WIDE_W, d);
         drive(1'b1, d, 1'b0, 1'b1, 1'b0);
      end
      for (int i = 0; i < 20; i++) begin
         take_bits(WIDE_W, d);
         drive(1'b1, d, 1'b1, 1'b0, 1'b0);
      end
      test_name = "rst_i without clk_en";
      repeat (4) drive(1'b0, '0, 1'b0, 1'b0, 1'b1);

      test_name = "rst_i clear";
      repeat (2) drive(1'b0, '0, 1'b0, 1'b1, 1'b1);
      test_name = "after clear";
      for (int i = 0; i < 3; i++) begin
         take_bits(WIDE_W, d);
         drive(1'b1, d, 1'b0, 1'b1, 1'b0);
      end
      repeat (12) drive(1'b0, '0, 1'b1, 1'b1, 1'b0);
      drive(1'b0, '0, 1'b0, 1'b1, 1'b0);

      repeat (2) @(negedge clk_i);
      @(posedge clk_i);
      $display("checks: %0d errors: %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      #(TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
      $display("watchdog timeout: the stimulus did not finish in time");
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/fifo_cfg_pkg.sv
rtl/fifo_mem_pkg.sv
rtl/lane_ram.sv
rtl/ram_2p_asym.sv
rtl/fifo_sync_asym.sv
rtl/fifo_subsys_top.sv
tests/tb_fifo_sync.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_fifo_sync
FILE_LIST ?= list.f
BUILD_DIR ?= build
LOG ?= $(BUILD_DIR)/sim.log
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= TESTBENCH PASSED

SRCS := $(filter-out +%,$(shell cat $(FILE_LIST)))
BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR)
